// File: source/n2r_defines.svh
/*
 * Matrix, slice and bus dimensions for the row-major to slice-order reshaper.
 * Included by the package and by every module that sizes logic from these values.
 */
`ifndef N2R_DEFINES_SVH
`define N2R_DEFINES_SVH

// Matrix geometry
`define N2R_ELEM_W      16
`define N2R_ROWS        8
`define N2R_COLS        8

// Core bank shape
`define N2R_BLOCK       2
`define N2R_CORES       2
`define N2R_SLICE_ROWS  (`N2R_BLOCK * `N2R_CORES)
`define N2R_CHUNKS      (`N2R_COLS / `N2R_BLOCK)
`define N2R_SLICES      (`N2R_ROWS / `N2R_SLICE_ROWS)

// Wishbone sizing and address map
`define N2R_WB_ADR_W    8
`define N2R_WB_DAT_W    32
// Word address bit that selects the control register
`define N2R_CTRL_BIT    6

`endif

// File: source/n2r_pkg.sv
/*
 * Shared types for the reshaper datapath and its control FSM.
 */
`default_nettype none

`include "n2r_defines.svh"

package n2r_pkg;

    typedef logic [`N2R_ELEM_W-1:0] elem_t;

    // Flat index, row * columns + column
    typedef logic [$clog2(`N2R_ROWS * `N2R_COLS)-1:0] elem_addr_t;

    // Band row 0 in the top bits, lower column higher within a row
    typedef logic [`N2R_SLICE_ROWS*`N2R_BLOCK*`N2R_ELEM_W-1:0] beat_t;

    typedef logic [$clog2(`N2R_SLICES + 1)-1:0] slice_idx_t;
    typedef logic [$clog2(`N2R_CHUNKS)-1:0]     chunk_idx_t;

    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_LOAD,
        CTRL_EMIT,
        CTRL_DONE
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: source/n2r_wb_port.sv
/*
 * Wishbone classic slave for the reshaper. Element writes go straight to the RAM,
 * a write to the control register starts a run, a read returns busy and done.
 */
`default_nettype none

`include "n2r_defines.svh"

module n2r_wb_port
    import n2r_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  logic [`N2R_WB_ADR_W-1:0] wb_adr,
    input  logic [`N2R_WB_DAT_W-1:0] wb_dat_i,
    output logic [`N2R_WB_DAT_W-1:0] wb_dat_o,
    output logic                     wb_ack,
    output logic                     wr_en,
    output elem_addr_t               wr_addr,
    output elem_t                    wr_data,
    output logic                     start,
    input  logic                     busy,
    input  logic                     done
);

    logic req;
    logic ctrl_sel;
    logic [`N2R_WB_DAT_W-1:0] status;

    // New access, not yet acknowledged
    assign req      = wb_cyc && wb_stb && !wb_ack;
    assign ctrl_sel = wb_adr[`N2R_CTRL_BIT];

    // RAM write lands on the same edge that raises ack
    assign wr_en   = req && wb_we && !ctrl_sel;
    assign wr_addr = wb_adr[$bits(elem_addr_t)-1:0];
    assign wr_data = wb_dat_i[$bits(elem_t)-1:0];

    assign status = {{(`N2R_WB_DAT_W - 2){1'b0}}, done, busy};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
            start  <= 1'b0;
        end else begin
            wb_ack <= req;
            // Start pulse lines up with the ack
            start  <= req && wb_we && ctrl_sel && wb_dat_i[0];
        end
    end

    // Read data valid together with ack
    always_ff @(posedge clk) begin
        if (req && !wb_we) begin
            if (ctrl_sel) begin
                wb_dat_o <= status;
            end else begin
                // Element RAM is write only from the bus
                wb_dat_o <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/n2r_row_ram.sv
/*
 * Element store for the whole matrix in row-major order.
 * One write port from the bus side, one registered read port for the loader.
 */
`default_nettype none

`include "n2r_defines.svh"

module n2r_row_ram
    import n2r_pkg::*;
(
    input  logic       clk,
    input  logic       wr_en,
    input  elem_addr_t wr_addr,
    input  elem_t      wr_data,
    input  elem_addr_t rd_addr,
    output elem_t      rd_data
);

    localparam int DEPTH = `N2R_ROWS * `N2R_COLS;

    elem_t mem [DEPTH];

    // Synchronous write and read, maps onto a simple dual port block RAM
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// File: source/n2r_ctrl.sv
/*
 * Sequencing FSM for the reshaper. After a start it loads each band, then emits
 * one beat per column block, and flags the end of every band and of the matrix.
 */
`default_nettype none

`include "n2r_defines.svh"

module n2r_ctrl
    import n2r_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  logic       load_done,
    output logic       load_start,
    output elem_addr_t band_base,
    output logic       emit_en,
    output chunk_idx_t chunk_idx,
    output logic       slice_done,
    output logic       buffer_done,
    output logic       busy
);

    localparam int BAND_ELEMS = `N2R_SLICE_ROWS * `N2R_COLS;

    ctrl_state_t state;
    ctrl_state_t state_next;
    slice_idx_t  slice_cnt;
    chunk_idx_t  chunk_cnt;
    logic        start_ok;
    logic        last_chunk;
    logic        last_slice;

    // Busy runs until done is flagged, which is one cycle after the last beat
    assign busy       = (state != CTRL_IDLE) && !buffer_done;
    assign start_ok   = start && !busy;
    assign last_chunk = (chunk_cnt == chunk_idx_t'(`N2R_CHUNKS - 1));
    assign last_slice = (slice_cnt == slice_idx_t'(`N2R_SLICES - 1));

    assign emit_en   = (state == CTRL_EMIT);
    assign chunk_idx = chunk_cnt;
    assign band_base = elem_addr_t'(int'(slice_cnt) * BAND_ELEMS);

    always_comb begin
        state_next = state;
        case (state)
            CTRL_IDLE: begin
                if (start_ok) begin
                    state_next = CTRL_LOAD;
                end
            end
            CTRL_LOAD: begin
                if (load_done) begin
                    state_next = CTRL_EMIT;
                end
            end
            CTRL_EMIT: begin
                if (last_chunk) begin
                    if (last_slice) begin
                        state_next = CTRL_DONE;
                    end else begin
                        state_next = CTRL_LOAD;
                    end
                end
            end
            CTRL_DONE: begin
                // New matrix may follow without a reset
                if (start_ok) begin
                    state_next = CTRL_LOAD;
                end
            end
            default: begin
                state_next = CTRL_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= CTRL_IDLE;
            slice_cnt   <= '0;
            chunk_cnt   <= '0;
            load_start  <= 1'b0;
            slice_done  <= 1'b0;
            buffer_done <= 1'b0;
        end else begin
            state <= state_next;

            // One load request on every entry into LOAD
            load_start <= (state_next == CTRL_LOAD) && (state != CTRL_LOAD);

            // Delayed to match the registered beat in the emitter
            slice_done <= emit_en && last_chunk;

            // Held until the next accepted start
            buffer_done <= (state == CTRL_DONE) && !start_ok;

            if (start_ok) begin
                slice_cnt <= '0;
            end else if (emit_en && last_chunk && !last_slice) begin
                slice_cnt <= slice_cnt + 1'b1;
            end

            if (emit_en) begin
                chunk_cnt <= last_chunk ? '0 : chunk_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/n2r_slice_loader.sv
/*
 * Reads one band of rows out of the element RAM and keeps it in a register file.
 * The flattened band feeds the emitter until the next load overwrites it.
 */
`default_nettype none

`include "n2r_defines.svh"

module n2r_slice_loader
    import n2r_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       load_start,
    input  elem_addr_t band_base,
    input  elem_t      rd_data,
    output elem_addr_t rd_addr,
    output logic       load_done,
    output logic [`N2R_SLICE_ROWS*`N2R_COLS*`N2R_ELEM_W-1:0] slice_flat
);

    localparam int BAND_ELEMS = `N2R_SLICE_ROWS * `N2R_COLS;
    localparam int IDX_W      = $clog2(BAND_ELEMS);
    localparam int W          = `N2R_ELEM_W;

    elem_t            band_q [BAND_ELEMS];
    logic [IDX_W-1:0] idx;
    logic [IDX_W-1:0] idx_d;
    logic             active;
    logic             rd_vld;
    logic             last_idx;

    assign last_idx = (idx == IDX_W'(BAND_ELEMS - 1));

    // Band is contiguous in row-major order
    assign rd_addr = band_base + elem_addr_t'(idx);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active    <= 1'b0;
            rd_vld    <= 1'b0;
            load_done <= 1'b0;
            idx       <= '0;
        end else begin
            rd_vld    <= active;
            // Last element returns on the cycle this pulse is high
            load_done <= active && last_idx;
            if (load_start) begin
                active <= 1'b1;
                idx    <= '0;
            end else if (active) begin
                idx <= idx + 1'b1;
                if (last_idx) begin
                    active <= 1'b0;
                end
            end
        end
    end

    // Index delayed by the RAM read latency steers the returning element
    always_ff @(posedge clk) begin
        idx_d <= idx;
        if (rd_vld) begin
            band_q[idx_d] <= rd_data;
        end
    end

    always_comb begin
        for (int i = 0; i < BAND_ELEMS; i++) begin
            slice_flat[i*W +: W] = band_q[i];
        end
    end

endmodule

`default_nettype wire

// File: source/n2r_chunk_emitter.sv
/*
 * Builds one output beat per cycle from the loaded band.
 * Each band row contributes the column block picked by chunk_idx.
 */
`default_nettype none

`include "n2r_defines.svh"

module n2r_chunk_emitter
    import n2r_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       emit_en,
    input  chunk_idx_t chunk_idx,
    input  logic [`N2R_SLICE_ROWS*`N2R_COLS*`N2R_ELEM_W-1:0] slice_flat,
    output logic       out_valid,
    output beat_t      out_beat
);

    localparam int ROWS  = `N2R_SLICE_ROWS;
    localparam int COLS  = `N2R_COLS;
    localparam int BLOCK = `N2R_BLOCK;
    localparam int W     = `N2R_ELEM_W;

    beat_t beat_next;

    always_comb begin
        int src;
        int dst;
        beat_next = '0;
        for (int r = 0; r < ROWS; r++) begin
            for (int k = 0; k < BLOCK; k++) begin
                src = r * COLS + int'(chunk_idx) * BLOCK + k;
                // Row 0 on top, first column of the block above the next
                dst = (ROWS - 1 - r) * BLOCK + (BLOCK - 1 - k);
                beat_next[dst*W +: W] = slice_flat[src*W +: W];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= emit_en;
        end
    end

    always_ff @(posedge clk) begin
        if (emit_en) begin
            out_beat <= beat_next;
        end
    end

endmodule

`default_nettype wire

// File: source/n2r_reshaper.sv
/*
 * Top of the reshaper. The host fills the matrix over Wishbone and starts a run,
 * the core bank receives slice-ordered beats with band and matrix end markers.
 */
`default_nettype none

`include "n2r_defines.svh"

module n2r_reshaper
    import n2r_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  logic [`N2R_WB_ADR_W-1:0] wb_adr,
    input  logic [`N2R_WB_DAT_W-1:0] wb_dat_i,
    output logic [`N2R_WB_DAT_W-1:0] wb_dat_o,
    output logic                     wb_ack,
    output logic                     out_valid,
    output beat_t                    out_beat,
    output logic                     slice_done,
    output logic                     buffer_done
);

    logic       wr_en;
    elem_addr_t wr_addr;
    elem_t      wr_data;
    logic       start;
    logic       busy;
    logic       load_start;
    logic       load_done;
    elem_addr_t band_base;
    elem_addr_t rd_addr;
    elem_t      rd_data;
    logic       emit_en;
    chunk_idx_t chunk_idx;
    logic [`N2R_SLICE_ROWS*`N2R_COLS*`N2R_ELEM_W-1:0] slice_flat;

    n2r_wb_port u_wb_port (
        .clk(clk), .rst_n(rst_n),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack(wb_ack),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .start(start), .busy(busy), .done(buffer_done)
    );

    n2r_row_ram u_row_ram (
        .clk(clk), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .rd_addr(rd_addr), .rd_data(rd_data)
    );

    n2r_ctrl u_ctrl (
        .clk(clk), .rst_n(rst_n), .start(start), .load_done(load_done),
        .load_start(load_start), .band_base(band_base),
        .emit_en(emit_en), .chunk_idx(chunk_idx),
        .slice_done(slice_done), .buffer_done(buffer_done), .busy(busy)
    );

    n2r_slice_loader u_loader (
        .clk(clk), .rst_n(rst_n), .load_start(load_start), .band_base(band_base),
        .rd_data(rd_data), .rd_addr(rd_addr), .load_done(load_done),
        .slice_flat(slice_flat)
    );

    n2r_chunk_emitter u_emitter (
        .clk(clk), .rst_n(rst_n), .emit_en(emit_en), .chunk_idx(chunk_idx),
        .slice_flat(slice_flat), .out_valid(out_valid), .out_beat(out_beat)
    );

endmodule

`default_nettype wire

// File: dv/n2r_reshaper_props.sv
/*
 * Protocol assertions for the reshaper, attached to the top level with bind.
 */
`default_nettype none

module n2r_reshaper_props (
    input logic clk,
    input logic rst_n,
    input logic wb_ack,
    input logic out_valid,
    input logic slice_done,
    input logic buffer_done,
    input logic busy
);

    timeunit 1ns;
    timeprecision 1ps;

    // Every access gets a single-cycle ack
    ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) wb_ack |=> !wb_ack)
        else $error("wb_ack stayed high for more than one cycle");

    slice_done_on_beat: assert property (@(posedge clk) disable iff (!rst_n)
        slice_done |-> out_valid)
        else $error("slice_done without out_valid");

    // No beats once the matrix is finished
    no_beat_when_done: assert property (@(posedge clk) disable iff (!rst_n)
        !(out_valid && buffer_done))
        else $error("out_valid while buffer_done is high");

    reset_values: assert property (@(posedge clk)
        !rst_n |=> !(out_valid || slice_done || buffer_done || wb_ack || busy))
        else $error("control outputs not low after reset");

endmodule

bind n2r_reshaper n2r_reshaper_props u_props (
    .clk(clk),
    .rst_n(rst_n),
    .wb_ack(wb_ack),
    .out_valid(out_valid),
    .slice_done(slice_done),
    .buffer_done(buffer_done),
    .busy(busy)
);

`default_nettype wire

// File: dv/n2r_reshaper_tb.sv
/*
 * Testbench for the reshaper. Loads random matrices over Wishbone, starts runs
 * and checks every beat and end marker against a reference model.
 */
`default_nettype none

`include "n2r_defines.svh"

module n2r_reshaper_tb
    import n2r_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int W          = `N2R_ELEM_W;
    localparam int DAT_W      = `N2R_WB_DAT_W;
    localparam int COLS       = `N2R_COLS;
    localparam int BLOCK      = `N2R_BLOCK;
    localparam int SLICE_ROWS = `N2R_SLICE_ROWS;
    localparam int CHUNKS     = `N2R_CHUNKS;
    localparam int SLICES     = `N2R_SLICES;
    localparam int BEATS      = SLICES * CHUNKS;
    localparam int BEAT_W     = $bits(beat_t);
    // Three clocks per bus access, then one band load and its beats per slice
    localparam int MATRIX_CYCLES = `N2R_ROWS * COLS * 3
                                 + SLICES * (SLICE_ROWS * COLS + CHUNKS + 4);
    localparam int TIMEOUT_CYCLES = 2 * MATRIX_CYCLES + 200;
    localparam logic [`N2R_WB_ADR_W-1:0] CTRL_ADR = `N2R_WB_ADR_W'(1) << `N2R_CTRL_BIT;

    logic                     clk;
    logic                     rst_n;
    logic                     wb_cyc;
    logic                     wb_stb;
    logic                     wb_we;
    logic [`N2R_WB_ADR_W-1:0] wb_adr;
    logic [DAT_W-1:0]         wb_dat_i;
    logic [DAT_W-1:0]         wb_dat_o;
    logic                     wb_ack;
    logic                     out_valid;
    beat_t                    out_beat;
    logic                     slice_done;
    logic                     buffer_done;

    elem_t model [`N2R_ROWS][COLS];
    int    beat_cnt = 0;
    int    slice_done_cnt = 0;
    int    cycle_cnt = 0;
    int    run_idx;
    int    band;
    int    chunk;
    logic  ack_q = 1'b0;

    n2r_reshaper uut (
        .clk(clk), .rst_n(rst_n),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack(wb_ack),
        .out_valid(out_valid), .out_beat(out_beat),
        .slice_done(slice_done), .buffer_done(buffer_done)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // Band rows in order, each row's block with its lower column first, first on top
    function automatic beat_t expected_beat(input int b, input int c);
        beat_t beat;
        beat = '0;
        for (int r = 0; r < SLICE_ROWS; r++) begin
            for (int k = 0; k < BLOCK; k++) begin
                beat = {beat[BEAT_W-W-1:0], model[b * SLICE_ROWS + r][c * BLOCK + k]};
            end
        end
        return beat;
    endfunction

    task automatic report_error(input string msg);
        $display("ERR %0t: %s", $time, msg);
        $display("Test failed");
    endtask

    task automatic bus_cycle(input logic we, input logic [`N2R_WB_ADR_W-1:0] adr,
                             input logic [DAT_W-1:0] wdata, output logic [DAT_W-1:0] rdata);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_i <= wdata;
        do begin
            @(posedge clk);
        end while (!wb_ack);
        rdata = wb_dat_o;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic load_matrix();
        logic [31:0]      rnd;
        logic [DAT_W-1:0] rdata;
        for (int r = 0; r < `N2R_ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                rnd = $urandom;
                model[r][c] = rnd[W-1:0];
                bus_cycle(1'b1, `N2R_WB_ADR_W'(r * COLS + c),
                          {{(DAT_W - W){1'b0}}, model[r][c]}, rdata);
            end
        end
    endtask

    task automatic send_start();
        logic [DAT_W-1:0] rdata;
        bus_cycle(1'b1, CTRL_ADR, DAT_W'(1), rdata);
    endtask

    task automatic check_status(input logic exp_busy, input logic exp_done);
        logic [DAT_W-1:0] rdata;
        bus_cycle(1'b0, CTRL_ADR, '0, rdata);
        assert (rdata == DAT_W'({exp_done, exp_busy})) else begin
            report_error($sformatf("status is %h, expected busy %0b done %0b",
                                   rdata, exp_busy, exp_done));
            $fatal(1, "status mismatch");
        end
    endtask

    task automatic check_counts(input int exp_beats, input int exp_slices);
        assert (beat_cnt == exp_beats && slice_done_cnt == exp_slices) else begin
            report_error($sformatf("%0d beats and %0d slice_done pulses, expected %0d and %0d",
                                   beat_cnt, slice_done_cnt, exp_beats, exp_slices));
            $fatal(1, "beat count mismatch");
        end
    endtask

    task automatic wait_for_done();
        while (!buffer_done) begin
            @(posedge clk);
        end
    endtask

    task automatic wait_for_slice_end();
        while (!slice_done) begin
            @(posedge clk);
        end
    endtask

    // Beat compare, position within the run follows from the beat count
    always @(posedge clk) begin
        if (rst_n) begin
            assert (!(slice_done && !out_valid) && !(out_valid && buffer_done)
                    && !(wb_ack && ack_q)) else begin
                $display("Protocol error: bad slice_done, out_valid or wb_ack timing");
                $display("Test failed");
                $fatal(1, "protocol violation");
            end
        end
        if (rst_n && out_valid) begin
            run_idx = beat_cnt % BEATS;
            band    = run_idx / CHUNKS;
            chunk   = run_idx % CHUNKS;
            assert (out_beat == expected_beat(band, chunk)) else begin
                report_error($sformatf("beat %0d band %0d chunk %0d is %h, expected %h",
                             beat_cnt, band, chunk, out_beat, expected_beat(band, chunk)));
                $fatal(1, "beat mismatch");
            end
            assert (slice_done == (chunk == CHUNKS - 1)) else begin
                report_error($sformatf("slice_done is %0b on chunk %0d", slice_done, chunk));
                $fatal(1, "slice_done misplaced");
            end
            beat_cnt <= beat_cnt + 1;
            if (slice_done) begin
                slice_done_cnt <= slice_done_cnt + 1;
            end
        end
        ack_q <= wb_ack;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failed");
            $fatal(1, "timeout");
        end
    end

    initial begin
        void'($urandom(32'hbe3c1bdf));
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_i = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        assert (!out_valid && !slice_done && !buffer_done && !wb_ack) else begin
            report_error("outputs not low after reset");
            $fatal(1, "reset values");
        end

        // Idle, nothing comes out without a start
        check_status(1'b0, 1'b0);
        repeat (20) @(posedge clk);
        check_counts(0, 0);

        // First matrix, a second start lands while the second band loads
        load_matrix();
        send_start();
        check_status(1'b1, 1'b0);
        wait_for_slice_end();
        send_start();
        wait_for_done();
        check_counts(BEATS, SLICES);
        check_status(1'b0, 1'b1);

        // Second matrix overwrites the RAM after done
        load_matrix();
        check_status(1'b0, 1'b1);
        send_start();
        check_status(1'b1, 1'b0);
        wait_for_done();
        check_counts(2 * BEATS, 2 * SLICES);
        check_status(1'b0, 1'b1);

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: n2r_reshaper.f
+incdir+source
source/n2r_pkg.sv
source/n2r_wb_port.sv
source/n2r_row_ram.sv
source/n2r_ctrl.sv
source/n2r_slice_loader.sv
source/n2r_chunk_emitter.sv
source/n2r_reshaper.sv
dv/n2r_reshaper_props.sv
dv/n2r_reshaper_tb.sv

// File: Makefile
SIM = obj_dir/n2r_reshaper_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f n2r_reshaper.f --top-module n2r_reshaper_tb -o n2r_reshaper_tb

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; \
		echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir
